// ==== logic/heading_error.sv ====
// Heading error stage that holds the desired heading and forms the nudged PID error.
`timescale 1ns/1ps
`include "knight_cmd_cfg.svh"

module heading_error (
  input  logic                         clk,
  input  logic                         rst_n,
  input  knight_cmd_pkg::motion_ctrl_t ctrl,     // Only load_move is used here.
  input  knight_cmd_pkg::cmd_t         cmd,      // Bits 11..4 carry the heading.
  input  knight_cmd_pkg::heading_t     heading,  // Gyro heading.
  input  logic                         lft_ir,   // Robot drifted onto the left line.
  input  logic                         rght_ir,  // Robot drifted onto the right line.
  output knight_cmd_pkg::heading_t     error,    // Error to the PID controller.
  output logic                         aligned   // Error is inside the alignment window.
);

  import knight_cmd_pkg::*;

  heading_t    desired;    // Heading the robot should hold.
  heading_t    nudge;      // Correction from the side IR sensors.
  logic [11:0] error_abs;  // Magnitude of the error.

  // Nonzero headings get four ones appended so they land mid-step.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      desired <= '0;
    end else if (ctrl.load_move) begin
      if (cmd[11:4] == 8'h00) begin
        desired <= '0;  // North stays exactly zero.
      end else begin
        desired <= {cmd[11:4], 4'hF};
      end
    end
  end

  // Left has priority when both sensors fire.
  assign nudge = lft_ir  ? heading_t'(`KNIGHT_NUDGE_LFT)  :
                 rght_ir ? heading_t'(`KNIGHT_NUDGE_RGHT) :
                           heading_t'(12'h000);

  assign error = heading - desired + nudge;  // Wraps naturally in 12 bits.

  assign error_abs = error[11] ? 12'(-error) : 12'(error);  // Two's complement magnitude.

  assign aligned = (error_abs < `KNIGHT_ALIGN_THRESH);

endmodule

// ==== logic/knight_cmd_cfg.svh ====
// Knight command processor tuning constants for speed ramp, IR nudge and alignment.
`ifndef KNIGHT_CMD_CFG_SVH
`define KNIGHT_CMD_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Simulation speed selection
////////////////////////////////////////////////////////////////////////////
// Set to 1 for the short ramps used in simulation, 0 for the real robot.
`define KNIGHT_FAST_SIM 1

////////////////////////////////////////////////////////////////////////////
// Forward speed ramp steps
////////////////////////////////////////////////////////////////////////////
`define KNIGHT_INC_AMT ((`KNIGHT_FAST_SIM != 0) ? 10'd32 : 10'd3)   // Added per heading update.
`define KNIGHT_DEC_AMT ((`KNIGHT_FAST_SIM != 0) ? 10'd64 : 10'd6)   // Removed per heading update.

////////////////////////////////////////////////////////////////////////////
// Heading error nudges and alignment window
////////////////////////////////////////////////////////////////////////////
// The left IR sensor pushes the error positive so the PID steers back right.
`define KNIGHT_NUDGE_LFT ((`KNIGHT_FAST_SIM != 0) ? 12'h1FF : 12'h05F)
// The right IR sensor pushes the error negative.
`define KNIGHT_NUDGE_RGHT ((`KNIGHT_FAST_SIM != 0) ? 12'hE00 : 12'hFA1)
// Heading counts as aligned while the absolute error is below this.
`define KNIGHT_ALIGN_THRESH 12'h02C

`endif

// ==== logic/knight_cmd_pkg.sv ====
// Knight command processor types shared by the sequencer and its datapath stages.
package knight_cmd_pkg;

  typedef logic [15:0]        cmd_t;        // Command word from the wireless link.
  typedef logic signed [11:0] heading_t;    // Gyro heading and heading error.
  typedef logic [9:0]         speed_t;      // Forward speed handed to the motor drive.
  typedef logic [3:0]         sq_cnt_t;     // Number of squares to travel.
  typedef logic [4:0]         pulse_cnt_t;  // Center IR edges seen, two per square.

  // Opcode held in the top nibble of the command word.
  typedef enum logic [3:0] {
    CAL     = 4'h2,  // Start gyro calibration.
    MOV     = 4'h4,  // Plain move.
    FANFARE = 4'h5,  // Move with the fanfare at the end.
    TOUR    = 4'h6   // Hand over to the tour engine.
  } opcode_t;

  typedef enum logic [2:0] {IDLE, CALIBRATE, TURN, RAMP_UP, RAMP_DOWN} seq_state_t;

  // Commands from the sequencer to the datapath stages.
  typedef struct packed {
    logic load_move;  // Latch heading and square count from the command.
    logic clr_speed;  // Zero the forward speed.
    logic inc_speed;  // Ramp speed up on heading updates.
    logic dec_speed;  // Ramp speed down on heading updates.
  } motion_ctrl_t;

  // Status returned from the stages.
  typedef struct packed {
    logic aligned;     // Heading error inside the alignment window.
    logic speed_zero;  // Forward speed has reached zero.
    logic move_done;   // All square crossings have been seen.
  } motion_stat_t;

endpackage

// ==== logic/knight_cmd_top.sv ====
// Knight command processor top that joins the move sequencer to its three datapath stages.
`timescale 1ns/1ps

module knight_cmd_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  knight_cmd_pkg::cmd_t     cmd,          // Command word from the link.
  input  logic                     cmd_rdy,      // Command waiting.
  input  logic                     cal_done,     // Gyro calibration done.
  input  knight_cmd_pkg::heading_t heading,      // Gyro heading.
  input  logic                     heading_rdy,  // New heading pulse.
  input  logic                     lft_ir,       // Left line sensor.
  input  logic                     cntr_ir,      // Center line sensor.
  input  logic                     rght_ir,      // Right line sensor.
  output logic                     clr_cmd_rdy,  // Command taken.
  output logic                     send_resp,    // Command finished.
  output logic                     strt_cal,     // Start calibration.
  output knight_cmd_pkg::heading_t error,        // Heading error to the PID.
  output knight_cmd_pkg::speed_t   frwrd,        // Forward speed.
  output logic                     moving,       // Robot in motion.
  output logic                     tour_go,      // Start the tour engine.
  output logic                     fanfare_go    // Start the fanfare.
);

  import knight_cmd_pkg::*;

  motion_ctrl_t ctrl;  // Sequencer controls fanned out to the stages.
  motion_stat_t stat;  // Stage status gathered for the sequencer.

  move_sequencer u_move_sequencer (
    .clk, .rst_n, .cmd, .cmd_rdy, .cal_done, .stat, .ctrl,
    .clr_cmd_rdy, .strt_cal, .send_resp, .tour_go, .fanfare_go, .moving
  );

  heading_error u_heading_error (
    .clk, .rst_n, .ctrl, .cmd, .heading, .lft_ir, .rght_ir,
    .error, .aligned (stat.aligned)
  );

  speed_ramp u_speed_ramp (
    .clk, .rst_n, .ctrl, .heading_rdy, .frwrd, .speed_zero (stat.speed_zero)
  );

  square_counter u_square_counter (
    .clk, .rst_n, .ctrl, .cmd, .cntr_ir, .move_done (stat.move_done)
  );

endmodule

// ==== logic/move_sequencer.sv ====
// Command decode FSM that steers calibration, turning and the speed ramps of a move.
`timescale 1ns/1ps

module move_sequencer (
  input  logic                        clk,
  input  logic                        rst_n,
  input  knight_cmd_pkg::cmd_t        cmd,          // Command word, valid while cmd_rdy is high.
  input  logic                        cmd_rdy,      // New command waiting.
  input  logic                        cal_done,     // Gyro calibration finished.
  input  knight_cmd_pkg::motion_stat_t stat,        // Status from the datapath stages.
  output knight_cmd_pkg::motion_ctrl_t ctrl,        // Controls to the datapath stages.
  output logic                        clr_cmd_rdy,  // Marks the command as taken.
  output logic                        strt_cal,     // Kicks off gyro calibration.
  output logic                        send_resp,    // Command finished.
  output logic                        tour_go,      // Starts the tour engine.
  output logic                        fanfare_go,   // Starts the fanfare tune.
  output logic                        moving        // Robot is turning or driving.
);

  import knight_cmd_pkg::*;

  seq_state_t state;      // Current state.
  seq_state_t nxt_state;  // Next state from the decode logic.
  opcode_t    opcode;     // Opcode field of the command.
  logic       is_fanfare; // Set when the running move came from a FANFARE command.

  assign opcode = opcode_t'(cmd[15:12]);  // Top nibble carries the opcode.

  ////////////////////////////////////////////////////////////////////////////
  // State and move-type registers
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= nxt_state;  // Advance every cycle.
    end
  end

  // The command word may change once taken, so remember the move type here.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      is_fanfare <= 1'b0;
    end else if (ctrl.load_move) begin
      is_fanfare <= (opcode == FANFARE);  // Latched in the accepting cycle.
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next-state and output decode
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    nxt_state   = state;  // Hold by default.
    ctrl        = '0;     // No datapath action by default.
    clr_cmd_rdy = 1'b0;
    strt_cal    = 1'b0;
    send_resp   = 1'b0;
    tour_go     = 1'b0;
    fanfare_go  = 1'b0;
    moving      = 1'b0;
    case (state)
      CALIBRATE: begin
        if (cal_done) begin
          send_resp = 1'b1;  // Acknowledge in the cycle the gyro reports done.
          nxt_state = IDLE;
        end
      end
      TURN: begin
        moving = 1'b1;  // Turning in place counts as moving for yaw integration.
        if (stat.aligned) begin
          ctrl.clr_speed = 1'b1;  // Start the ramp from standstill.
          nxt_state      = RAMP_UP;
        end
      end
      RAMP_UP: begin
        moving         = 1'b1;
        ctrl.inc_speed = 1'b1;  // Accelerate until the square count is met.
        if (stat.move_done) begin
          fanfare_go = is_fanfare;  // One pulse, only for FANFARE.
          nxt_state  = RAMP_DOWN;
        end
      end
      RAMP_DOWN: begin
        ctrl.dec_speed = 1'b1;  // Brake on each heading update.
        if (stat.speed_zero) begin
          send_resp = 1'b1;  // Move complete.
          nxt_state = IDLE;
        end else begin
          moving = 1'b1;  // Still rolling.
        end
      end
      default: begin  // IDLE waits for a command.
        if (cmd_rdy) begin
          clr_cmd_rdy = 1'b1;  // Every command is taken in this cycle.
          case (opcode)
            TOUR: tour_go = 1'b1;  // Tour engine takes over, we stay idle.
            CAL: begin
              strt_cal  = 1'b1;
              nxt_state = CALIBRATE;
            end
            MOV, FANFARE: begin
              ctrl.load_move = 1'b1;  // Stages latch heading and squares now.
              nxt_state      = TURN;
            end
            default: nxt_state = IDLE;  // Unknown opcodes are dropped.
          endcase
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Protocol checks
  ////////////////////////////////////////////////////////////////////////////
  // The speed stage would resolve both at once by priority, which hides a decode bug.
  a_no_inc_dec: assert property (@(posedge clk) disable iff (!rst_n)
    !(ctrl.inc_speed && ctrl.dec_speed));

  // A response always closes a command that left IDLE in an earlier cycle.
  a_resp_not_idle: assert property (@(posedge clk) disable iff (!rst_n)
    send_resp |-> (state != IDLE) && $past(ctrl.load_move || strt_cal || state != IDLE));

endmodule

// ==== logic/speed_ramp.sv ====
// Forward speed register that ramps up or down on each gyro heading update.
`timescale 1ns/1ps
`include "knight_cmd_cfg.svh"

module speed_ramp (
  input  logic                         clk,
  input  logic                         rst_n,
  input  knight_cmd_pkg::motion_ctrl_t ctrl,         // clr, inc and dec speed are used.
  input  logic                         heading_rdy,  // One-cycle pulse per new heading.
  output knight_cmd_pkg::speed_t       frwrd,        // Forward speed.
  output logic                         speed_zero    // Speed has reached zero.
);

  import knight_cmd_pkg::*;

  localparam speed_t INC_AMT = `KNIGHT_INC_AMT;  // Step size going up.
  localparam speed_t DEC_AMT = `KNIGHT_DEC_AMT;  // Step size going down.

  logic at_max;  // Both top bits set.

  assign at_max     = &frwrd[9:8];
  assign speed_zero = (frwrd == '0);

  // Updates are paced by heading_rdy so the ramp tracks the gyro rate.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frwrd <= '0;
    end else if (ctrl.clr_speed) begin
      frwrd <= '0;
    end else if (heading_rdy) begin
      if (ctrl.inc_speed && !at_max) begin
        frwrd <= frwrd + INC_AMT;
      end else if (ctrl.dec_speed && !speed_zero) begin
        frwrd <= (frwrd < DEC_AMT) ? '0 : frwrd - DEC_AMT;  // Saturate at zero.
      end
    end
  end

  // An increment must land at or below full scale, never wrap past it.
  a_inc_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
    (heading_rdy && ctrl.inc_speed && !ctrl.clr_speed && !at_max) |=> (frwrd > $past(frwrd)));

endmodule

// ==== logic/square_counter.sv ====
// Square counter that counts center IR edges and flags when the commanded run is done.
`timescale 1ns/1ps

module square_counter (
  input  logic                         clk,
  input  logic                         rst_n,
  input  knight_cmd_pkg::motion_ctrl_t ctrl,      // Only load_move is used here.
  input  knight_cmd_pkg::cmd_t         cmd,       // Bits 3..0 carry the square count.
  input  logic                         cntr_ir,   // Center IR sees a line.
  output logic                         move_done  // Two edges per square seen.
);

  import knight_cmd_pkg::*;

  sq_cnt_t    square_cnt;   // Squares asked for.
  pulse_cnt_t pulse_cnt;    // Rising edges counted so far.
  logic       cntr_ir_q;    // Center IR from the last cycle.
  logic       ir_rise;      // Rising edge on the center IR.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cntr_ir_q <= 1'b0;
    end else begin
      cntr_ir_q <= cntr_ir;  // Delay for edge detect.
    end
  end

  assign ir_rise = cntr_ir & ~cntr_ir_q;

  // Each square has two crossing lines, hence two edges per square.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      square_cnt <= '0;
      pulse_cnt  <= '0;
    end else if (ctrl.load_move) begin
      square_cnt <= cmd[3:0];  // Start a fresh run.
      pulse_cnt  <= '0;
    end else if (ir_rise) begin
      pulse_cnt <= pulse_cnt + 1'b1;
    end
  end

  assign move_done = (pulse_cnt == {square_cnt, 1'b0});

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the knight command processor simulation with Verilator.
cd "$(dirname "$0")" || exit 1
out=$( { verilator --binary --timing --assert -j 0 -f vlog.f --top-module knight_cmd_tb \
  -o knight_sim && ./obj_dir/knight_sim; } 2>&1 )
echo "$out"
echo "$out" | grep -qx "all tests passed" && echo "Simulation PASSED" || { echo "Simulation FAILED"; exit 1; }

// ==== tests/knight_cmd_checker.sv ====
// Checker that watches the knight command processor and scores each test as it ends.
`timescale 1ns/1ps
`include "knight_cmd_cfg.svh"

module knight_cmd_checker (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [3:0]               test_kind,    // 1 reset, 2 tour, 3 cal, 4 error, 5 mov, 6 fanfare.
  input  logic                     test_end,
  input  logic                     chk_err,
  input  knight_cmd_pkg::heading_t exp_error,
  input  knight_cmd_pkg::cmd_t     cmd,
  input  logic                     cal_done,
  input  logic                     cntr_ir,
  input  logic                     clr_cmd_rdy,
  input  logic                     send_resp,
  input  logic                     strt_cal,
  input  knight_cmd_pkg::heading_t error,
  input  knight_cmd_pkg::speed_t   frwrd,
  input  logic                     moving,
  input  logic                     tour_go,
  input  logic                     fanfare_go,
  output int                       fail_cnt,
  output int                       test_cnt
);

  import knight_cmd_pkg::*;

  localparam speed_t INC_AMT = `KNIGHT_INC_AMT;
  localparam speed_t DEC_AMT = `KNIGHT_DEC_AMT;

  int     fails = 0, tests = 0;
  int     tour_cnt = 0, clr_cnt = 0, cal_cnt = 0, resp_cnt = 0, fan_cnt = 0, rise_cnt = 0;
  bit     moved = 1'b0, bad = 1'b0;
  logic   prev_ir = 1'b0;
  speed_t prev_frwrd = '0, peak = '0, exp_dn;

  assign fail_cnt = fails;
  assign test_cnt = tests;

  // First speed step with both top bits set, as the ramp stops there.
  function automatic speed_t ramp_peak();
    speed_t s;
    s = '0;
    while (s[9:8] != 2'b11) s = s + INC_AMT;
    return s;
  endfunction

  task automatic flag(input string msg);
    $display("%s", msg);
    fails++;
    bad = 1'b1;
  endtask

  task automatic expect_val(input string name, input int got, input int want);
    if (got != want) flag($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, want));
  endtask

  task automatic score_test();
    tests++;
    case (test_kind)
      4'd1: begin
        expect_val("frwrd", int'(frwrd), 0);
        expect_val("clr_cmd_rdy pulses", clr_cnt, 0);
        expect_val("send_resp pulses", resp_cnt, 0);
        expect_val("strt_cal pulses", cal_cnt, 0);
        expect_val("tour_go pulses", tour_cnt, 0);
        expect_val("fanfare_go pulses", fan_cnt, 0);
        expect_val("moving", int'(moved), 0);
      end
      4'd2: begin
        expect_val("tour_go pulses", tour_cnt, 1);
        expect_val("clr_cmd_rdy pulses", clr_cnt, 1);
        expect_val("send_resp pulses", resp_cnt, 0);
      end
      4'd3: begin
        expect_val("strt_cal pulses", cal_cnt, 1);
        expect_val("clr_cmd_rdy pulses", clr_cnt, 1);
        expect_val("send_resp pulses", resp_cnt, 1);
      end
      4'd4: expect_val("send_resp pulses", resp_cnt, 1);
      default: begin
        expect_val("moving", int'(moved), 1);
        expect_val("frwrd peak", int'(peak), int'(ramp_peak()));
        expect_val("frwrd", int'(frwrd), 0);  // Back at standstill.
        expect_val("send_resp pulses", resp_cnt, 1);
        expect_val("fanfare_go pulses", fan_cnt, (test_kind == 4'd6) ? 1 : 0);
      end
    endcase
    $display("test %0d kind %0d: %s", tests, test_kind, bad ? "bad" : "ok");
    tour_cnt = 0;
    clr_cnt  = 0;
    cal_cnt  = 0;
    resp_cnt = 0;
    fan_cnt  = 0;
    rise_cnt = 0;
    moved    = 1'b0;
    bad      = 1'b0;
    peak     = '0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Cycle checks, sampled on the rising edge
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (rst_n) begin
      if (chk_err && error !== exp_error)
        flag($sformatf("Mismatch error: got 0x%03h expected 0x%03h", error, exp_error));
      if (test_kind == 4'd3 && send_resp !== cal_done)  // Response only with cal_done.
        flag($sformatf("Mismatch send_resp: got 0x%0h expected 0x%0h", send_resp, cal_done));
      if (tour_go && !clr_cmd_rdy) flag("tour_go pulsed without clr_cmd_rdy");
      if (cntr_ir && !prev_ir) rise_cnt++;
      if (fanfare_go) begin
        fan_cnt++;
        if (rise_cnt != 2 * int'(cmd[3:0])) flag("fanfare_go fired before the last IR edge");
        if (resp_cnt != 0) flag("fanfare_go fired after send_resp");
      end
      if (frwrd > prev_frwrd && frwrd != prev_frwrd + INC_AMT)
        flag($sformatf("Mismatch frwrd: got 0x%03h expected 0x%03h", frwrd, prev_frwrd + INC_AMT));
      exp_dn = (prev_frwrd < DEC_AMT) ? '0 : prev_frwrd - DEC_AMT;  // Saturating step down.
      if (frwrd < prev_frwrd && frwrd != exp_dn)
        flag($sformatf("Mismatch frwrd: got 0x%03h expected 0x%03h", frwrd, exp_dn));
      if (frwrd > peak) peak = frwrd;
      if (tour_go) tour_cnt++;
      if (clr_cmd_rdy) clr_cnt++;
      if (strt_cal) cal_cnt++;
      if (send_resp) resp_cnt++;
      if (moving) moved = 1'b1;
      if (test_end) score_test();
      prev_ir    = cntr_ir;
      prev_frwrd = frwrd;
    end
  end

endmodule

// ==== tests/knight_cmd_input.txt ====
// kind cmd heading lft_ir rght_ir exp_error, all hex, one test per line
// kind 1 reset, 2 tour, 3 cal, 4 heading error, 5 mov run, 6 fanfare run, 0 end
1 0000 000 0 0 000
2 6000 000 0 0 000
3 2000 000 0 0 000
4 4000 010 0 0 010
4 43F0 400 1 0 200
4 47F0 000 0 1 601
4 4BF0 C00 1 1 200
4 4120 100 0 0 FD1
4 4FF0 000 0 1 E01
5 4002 000 0 0 000
5 4A03 A0F 0 0 000
6 5001 000 0 0 000
6 52F2 2FF 0 0 000
0 0000 000 0 0 000

// ==== tests/knight_cmd_tb.sv ====
// Testbench top for the knight command processor, driving file stimulus on falling edges.
`timescale 1ns/1ps

module knight_cmd_tb;

  import knight_cmd_pkg::*;

  localparam int TIMEOUT = 200;  // Cycles any single wait may take.

  logic       clk = 1'b0;
  logic       rst_n;
  cmd_t       cmd;
  heading_t   heading, error, exp_error;
  speed_t     frwrd;
  logic       cmd_rdy, cal_done, heading_rdy, lft_ir, cntr_ir, rght_ir;
  logic       clr_cmd_rdy, send_resp, strt_cal, moving, tour_go, fanfare_go;
  logic [3:0] test_kind;   // Kind of the running test, seen by the checker.
  logic       test_end;    // One-cycle marker that closes a test.
  logic       chk_err;     // Asks the checker to compare error this cycle.
  int         fail_cnt, test_cnt;
  logic [15:0] vec [0:191]; // Six words per test line.
  logic [7:0] base;         // Word offset of the current test line.

  knight_cmd_top u_knight_cmd_top (.*);
  knight_cmd_checker u_knight_cmd_checker (.*);

  always #2 clk = ~clk;  // 4 ns period.

  // Rule for the desired heading, built from the command heading field.
  function automatic heading_t desired_heading(input cmd_t c);
    return (c[11:4] == 8'h00) ? 12'h000 : {c[11:4], 4'hF};
  endfunction

  task automatic finish_run(input bit timed_out);
    $display("%0d tests run, %0d check failures", test_cnt, fail_cnt);
    if (!timed_out && fail_cnt == 0 && test_cnt > 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  // Sel 0 waits for clr_cmd_rdy, sel 1 for send_resp. Pace toggles heading_rdy meanwhile.
  task automatic wait_for(input int sel, input bit pace, input string what);
    int n;
    bit seen;
    n = 0;
    seen = 1'b0;
    while (!seen && n < TIMEOUT) begin
      @(posedge clk);
      seen = (sel == 0) ? clr_cmd_rdy : send_resp;  // Sampled before the edge updates.
      n++;
      @(negedge clk);
      if (pace && !seen) heading_rdy = ~heading_rdy;
    end
    heading_rdy = 1'b0;
    if (!seen) begin
      $display("Timed out after %0d cycles waiting for %s", n, what);
      finish_run(1'b1);
    end
  endtask

  task automatic pace_heading(input int n);
    repeat (n) begin
      heading_rdy = 1'b1;  // One-cycle heading update.
      @(negedge clk);
      heading_rdy = 1'b0;
      @(negedge clk);
    end
  endtask

  task automatic cross_squares(input int n);
    repeat (2 * n) begin
      cntr_ir = 1'b1;  // Two line crossings per square.
      repeat (2) @(negedge clk);
      cntr_ir = 1'b0;
      repeat (2) @(negedge clk);
    end
  endtask

  task automatic run_test(input logic [7:0] b);
    logic [3:0] kind;
    kind      = vec[b][3:0];
    test_kind = kind;
    exp_error = vec[b + 8'd5][11:0];
    if (kind != 4'd1) begin
      cmd     = vec[b + 8'd1];
      heading = vec[b + 8'd2][11:0];
      lft_ir  = vec[b + 8'd3][0];
      rght_ir = vec[b + 8'd4][0];
      cmd_rdy = 1'b1;  // Level held until the DUT takes it.
      wait_for(0, 1'b0, "clr_cmd_rdy");
      cmd_rdy = 1'b0;
    end
    case (kind)
      4'd1, 4'd2: repeat (4) @(negedge clk);
      4'd3: begin
        repeat (5) @(negedge clk);  // No response may show before cal_done.
        cal_done = 1'b1;
        @(negedge clk);
        cal_done = 1'b0;
        repeat (2) @(negedge clk);
      end
      default: begin
        chk_err = 1'b1;  // Desired heading was latched at the accepting edge.
        @(negedge clk);
        chk_err = 1'b0;
        if (kind == 4'd4) begin
          heading = desired_heading(cmd);  // Zero squares, so the move ends at once.
          lft_ir  = 1'b0;
          rght_ir = 1'b0;
        end else begin
          pace_heading(30);  // Enough updates to reach full speed.
          cross_squares(int'(cmd[3:0]));
        end
        wait_for(1, 1'b1, "send_resp");
        repeat (2) @(negedge clk);
      end
    endcase
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    rst_n       = 1'b0;
    cmd         = '0;
    heading     = '0;
    cmd_rdy     = 1'b0;
    cal_done    = 1'b0;
    heading_rdy = 1'b0;
    lft_ir      = 1'b0;
    cntr_ir     = 1'b0;
    rght_ir     = 1'b0;
    test_kind   = 4'd0;
    test_end    = 1'b0;
    chk_err     = 1'b0;
    exp_error   = '0;
    $readmemh("tests/knight_cmd_input.txt", vec);
    repeat (16) @(posedge clk);  // Reset held for 16 cycles.
    @(negedge clk);
    rst_n = 1'b1;
    base  = 8'd0;
    while (base < 8'd186 && vec[base] >= 16'd1 && vec[base] <= 16'd6) begin
      run_test(base);
      base = base + 8'd6;
    end
    repeat (4) @(negedge clk);
    finish_run(1'b0);
  end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/knight_cmd_pkg.sv
logic/move_sequencer.sv
logic/heading_error.sv
logic/speed_ramp.sv
logic/square_counter.sv
logic/knight_cmd_top.sv
tests/knight_cmd_checker.sv
tests/knight_cmd_tb.sv
